//--- run.sh
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_rv_core -f verilog.f -o sim_tb_rv_core
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_rv_core 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" <<< "$sim_out"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- source/alu.sv
`timescale 1ns/100ps

module alu (
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    input  rv_pkg::alu_op_e op_i,
    output rv_pkg::word_t   y_o,
    output logic            zero_o,
    output logic            neg_o,
    output logic            ovf_o,
    output logic            carry_o
);

    rv_pkg::word_t diff;
    logic          no_borrow;
    logic [4:0]    shamt;

    // ------------------------------
    // subtract, source of all flags
    // ------------------------------
    assign {no_borrow, diff} = {1'b0, a_i} + {1'b0, ~b_i} + 33'd1;
    assign shamt = b_i[4:0];

    always_comb begin
        zero_o  = diff == '0;
        neg_o   = diff[31];
        ovf_o   = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
        carry_o = no_borrow; // set when a >= b unsigned
    end

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  y_o = a_i + b_i;
            rv_pkg::ALU_SUB:  y_o = diff;
            rv_pkg::ALU_SLL:  y_o = a_i << shamt;
            rv_pkg::ALU_SLT:  y_o = {31'b0, neg_o ^ ovf_o}; // signed less than
            rv_pkg::ALU_SLTU: y_o = {31'b0, !no_borrow};
            rv_pkg::ALU_XOR:  y_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  y_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  y_o = $signed(a_i) >>> shamt;
            rv_pkg::ALU_OR:   y_o = a_i | b_i;
            rv_pkg::ALU_AND:  y_o = a_i & b_i;
            default:          y_o = '0;
        endcase
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_pkg::fetch_t     fetch_i,
    input  rv_pkg::redirect_t  redirect_i,
    input  rv_pkg::retire_t    ex_fwd_i,
    input  rv_pkg::retire_t    retire_i,
    input  logic               valid_retire_i,
    output rv_pkg::decoded_t   dec_o
);

    rv_pkg::word_t    instr;
    rv_pkg::opcode_e  opcode;
    logic [2:0]       funct3;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    logic             supported;
    logic             we_raw;
    rv_pkg::word_t    rf_r1;
    rv_pkg::word_t    rf_r2;
    rv_pkg::decoded_t dec_d;
    rv_pkg::decoded_t dec_q;

    // funct3 plus the funct7 alternate bit
    function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    // youngest producer wins
    function automatic rv_pkg::word_t fwd_operand(
        input rv_pkg::reg_idx_t idx,
        input rv_pkg::word_t    rf_val,
        input rv_pkg::retire_t  ex,
        input rv_pkg::retire_t  ret,
        input logic             ret_ok
    );
        rv_pkg::word_t val;
        val = rf_val;
        if (idx != '0) begin
            if (ex.we && ex.rd == idx)
                val = ex.wdata; // in execute this cycle
            else if (ret_ok && ret.we && ret.rd == idx)
                val = ret.wdata; // written at the end of this cycle
        end
        return val;
    endfunction

    reg_file rf_u0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (retire_i.rd),
        .wr_i    (valid_retire_i && retire_i.we),
        .wdata_i (retire_i.wdata),
        .r1_o    (rf_r1),
        .r2_o    (rf_r2)
    );

    // ------------------------------
    // instruction decode
    // ------------------------------
    assign instr  = fetch_i.instr;
    assign opcode = rv_pkg::opcode_e'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        supported = 1'b1;
        we_raw    = 1'b1;
        dec_d.imm    = '0;
        dec_d.alu_op = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OP:     dec_d.alu_op = alu_decode(funct3, instr[30]);
            rv_pkg::OP_IMM: begin
                dec_d.imm    = rv_pkg::imm_i(instr);
                dec_d.alu_op = alu_decode(funct3, funct3 == 3'b101 && instr[30]); // srai only
            end
            rv_pkg::LUI,
            rv_pkg::AUIPC:  dec_d.imm = rv_pkg::imm_u(instr);
            rv_pkg::BRANCH: begin
                dec_d.imm = rv_pkg::imm_b(instr);
                we_raw    = 1'b0;
                supported = funct3[2:1] != 2'b01; // 010/011 reserved
            end
            rv_pkg::JAL:    dec_d.imm = rv_pkg::imm_j(instr);
            rv_pkg::JALR: begin
                dec_d.imm = rv_pkg::imm_i(instr);
                supported = funct3 == 3'b000;
            end
            default: supported = 1'b0; // becomes a bubble
        endcase
        if (instr[1:0] != 2'b11)
            supported = 1'b0;

        dec_d.pc      = fetch_i.pc;
        dec_d.instr   = instr;
        dec_d.opcode  = opcode;
        dec_d.funct3  = funct3;
        dec_d.rs1_val = fwd_operand(rs1, rf_r1, ex_fwd_i, retire_i, valid_retire_i);
        dec_d.rs2_val = fwd_operand(rs2, rf_r2, ex_fwd_i, retire_i, valid_retire_i);
        dec_d.rd      = rd;
        dec_d.we      = we_raw && rd != '0; // x0 writes dropped here
        dec_d.valid   = fetch_i.valid && supported && !redirect_i.taken;
    end

    // ------------------------------
    // decode to execute register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dec_q <= '0;
        else
            dec_q <= dec_d;
    end

    assign dec_o = dec_q;

    // the retire record comes back from execute
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_retire_i && retire_i.we) |-> (retire_i.rd != '0));

endmodule

//--- source/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::decoded_t  dec_i,
    output rv_pkg::redirect_t redirect_o,
    output rv_pkg::retire_t   ex_fwd_o,
    output rv_pkg::retire_t   retire_o,
    output logic              retire_valid_o
);

    rv_pkg::word_t   alu_b;
    rv_pkg::alu_op_e alu_op;
    rv_pkg::word_t   alu_y;
    logic            alu_zero;
    logic            alu_neg;
    logic            alu_ovf;
    logic            alu_carry;
    logic            branch_cond;
    rv_pkg::word_t   jalr_sum;
    rv_pkg::retire_t retire_q;
    logic            retire_valid_q;

    assign alu_b  = (dec_i.opcode == rv_pkg::OP_IMM) ? dec_i.imm : dec_i.rs2_val;
    assign alu_op = (dec_i.opcode == rv_pkg::BRANCH) ? rv_pkg::ALU_SUB : dec_i.alu_op;

    alu alu_u0 (
        .a_i     (dec_i.rs1_val),
        .b_i     (alu_b),
        .op_i    (alu_op),
        .y_o     (alu_y),
        .zero_o  (alu_zero),
        .neg_o   (alu_neg),
        .ovf_o   (alu_ovf),
        .carry_o (alu_carry)
    );

    // ------------------------------
    // branch and jump resolution
    // ------------------------------
    always_comb begin
        case (dec_i.funct3)
            3'b000:  branch_cond = alu_zero;              // beq
            3'b001:  branch_cond = !alu_zero;             // bne
            3'b100:  branch_cond = alu_neg ^ alu_ovf;     // blt
            3'b101:  branch_cond = !(alu_neg ^ alu_ovf);  // bge
            3'b110:  branch_cond = !alu_carry;            // bltu
            3'b111:  branch_cond = alu_carry;             // bgeu
            default: branch_cond = 1'b0;
        endcase
    end

    assign jalr_sum = dec_i.rs1_val + dec_i.imm;

    always_comb begin
        redirect_o.target = dec_i.pc + dec_i.imm; // imm is imm_b or imm_j here
        case (dec_i.opcode)
            rv_pkg::BRANCH: redirect_o.taken = branch_cond;
            rv_pkg::JAL:    redirect_o.taken = 1'b1;
            rv_pkg::JALR: begin
                redirect_o.taken  = 1'b1;
                redirect_o.target = {jalr_sum[31:1], 1'b0};
            end
            default:        redirect_o.taken = 1'b0;
        endcase
        if (!dec_i.valid)
            redirect_o.taken = 1'b0;
    end

    // result, also forwarded to decode
    always_comb begin
        case (dec_i.opcode)
            rv_pkg::LUI:   ex_fwd_o.wdata = dec_i.imm;
            rv_pkg::AUIPC: ex_fwd_o.wdata = dec_i.pc + dec_i.imm;
            rv_pkg::JAL,
            rv_pkg::JALR:  ex_fwd_o.wdata = dec_i.pc + 32'd4; // link
            default:       ex_fwd_o.wdata = alu_y;
        endcase
        ex_fwd_o.pc    = dec_i.pc;
        ex_fwd_o.rd    = dec_i.rd;
        ex_fwd_o.we    = dec_i.valid && dec_i.we;
        ex_fwd_o.instr = dec_i.instr;
    end

    // ------------------------------
    // retire register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            retire_valid_q <= 1'b0;
        else
            retire_valid_q <= dec_i.valid;
    end

    always_ff @(posedge clk) begin
        retire_q <= ex_fwd_o;
    end

    assign retire_o       = retire_q;
    assign retire_valid_o = retire_valid_q;

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o.taken |-> (redirect_o.target[1:0] == 2'b00));

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::redirect_t redirect_i,
    input  rv_pkg::word_t     instr_i,
    output rv_pkg::word_t     fetch_addr_o,
    output rv_pkg::fetch_t    fetch_o
);

    rv_pkg::word_t  pc_q;
    rv_pkg::fetch_t fetch_q;

    assign fetch_addr_o = pc_q; // memory answers in the same cycle

    // predict not taken, execute corrects us
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= rv_pkg::RESET_PC;
            fetch_q <= '0;
        end else begin
            pc_q          <= redirect_i.taken ? redirect_i.target : pc_q + 32'd4;
            fetch_q.pc    <= pc_q;
            fetch_q.instr <= instr_i;
            fetch_q.valid <= !redirect_i.taken; // word fetched now is on the wrong path
        end
    end

    assign fetch_o = fetch_q;

    // redirect targets come from execute, so alignment is a core-wide property
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00);

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  logic             wr_i,
    input  rv_pkg::word_t    wdata_i,
    output rv_pkg::word_t    r1_o,
    output rv_pkg::word_t    r2_o
);

    rv_pkg::word_t regs [1:31]; // no storage behind x0

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // read ports, combinational
    always_comb begin
        r1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
        r2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    end

endmodule

//--- source/rv_core.sv
`timescale 1ns/100ps

module rv_core (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::word_t   instr_i,
    output rv_pkg::word_t   fetch_addr_o,
    output logic            retire_valid_o,
    output rv_pkg::retire_t retire_o
);

    rv_pkg::fetch_t    fetch;
    rv_pkg::decoded_t  dec;
    rv_pkg::redirect_t redirect;
    rv_pkg::retire_t   ex_fwd;

    fetch_unit fetch_u0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect_i   (redirect),
        .instr_i      (instr_i),
        .fetch_addr_o (fetch_addr_o),
        .fetch_o      (fetch)
    );

    // retire record loops back for the register write
    decode_stage decode_u0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_i        (fetch),
        .redirect_i     (redirect),
        .ex_fwd_i       (ex_fwd),
        .retire_i       (retire_o),
        .valid_retire_i (retire_valid_o),
        .dec_o          (dec)
    );

    execute_stage execute_u0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec_i          (dec),
        .redirect_o     (redirect),
        .ex_fwd_o       (ex_fwd),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o)
    );

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC = 32'h0000_0000; // first fetch after reset

    // major opcode field, instr[6:2]
    typedef enum logic [4:0] {
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // ------------------------------
    // immediates, all sign extended
    // ------------------------------
    function automatic word_t imm_i(input word_t instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic word_t imm_s(input word_t instr);
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

    function automatic word_t imm_b(input word_t instr);
        return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    function automatic word_t imm_u(input word_t instr);
        return {instr[31:12], 12'b0};
    endfunction

    function automatic word_t imm_j(input word_t instr);
        return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

    // ------------------------------
    // pipeline records
    // ------------------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } fetch_t;

    typedef struct packed {
        word_t    pc;
        word_t    instr;    // carried along for the retire record
        opcode_e  opcode;
        logic [2:0] funct3;
        alu_op_e  alu_op;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;      // already selected per format
        reg_idx_t rd;
        logic     we;
        logic     valid;
    } decoded_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     we;
        word_t    instr;
    } retire_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

//--- verif/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

    logic            clk;
    logic            rst_n;
    rv_pkg::word_t   instr_i;
    rv_pkg::word_t   fetch_addr_o;
    logic            retire_valid_o;
    rv_pkg::retire_t retire_o;

    rv_pkg::word_t imem [0:1023];
    rv_pkg::word_t m_regs [0:31];   // reference register file
    rv_pkg::word_t m_pc;
    rv_pkg::word_t end_pc;          // address of the closing self jump
    logic [31:0]   lfsr = 32'hbcb3;
    int            wp = 0;          // next program slot
    int            total_len = 0;
    int            cycle_limit = 200;
    int            cycles = 0;
    int            errors = 0;
    int            test_err_base = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            n_retired = 0;
    int            since_release = 0;
    logic          active = 1'b0;
    logic          done = 1'b0;

    rv_core dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_i        (instr_i),
        .fetch_addr_o   (fetch_addr_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    assign instr_i = imem[fetch_addr_o[11:2]]; // answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // random bits and encoders
    // ------------------------------
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                             input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t op_imm(input logic [2:0] f3, input int rd,
                                             input int rs1, input int imm);
        return i_type(7'b0010011, f3, rd, rs1, imm);
    endfunction

    function automatic rv_pkg::word_t op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [6:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [2:0] f3, input int rs1,
                                             input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // ------------------------------
    // reference ISA model
    // ------------------------------
    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        rv_pkg::word_t y;
        case (f3)
            3'b000:  y = alt ? a - b : a + b;
            3'b001:  y = a << b[4:0];
            3'b010:  y = {31'b0, $signed(a) < $signed(b)};
            3'b011:  y = {31'b0, a < b};
            3'b100:  y = a ^ b;
            3'b101: begin
                if (alt)
                    y = $signed(a) >>> b[4:0];
                else
                    y = a >> b[4:0];
            end
            3'b110:  y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a,
                                        input rv_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // executes the word at m_pc and returns what should retire
    function automatic rv_pkg::retire_t ref_step();
        rv_pkg::retire_t r;
        rv_pkg::word_t   instr;
        rv_pkg::word_t   rs1v;
        rv_pkg::word_t   rs2v;
        rv_pkg::word_t   i_imm;
        rv_pkg::word_t   b_imm;
        rv_pkg::word_t   j_imm;
        rv_pkg::word_t   next;
        logic [2:0]      f3;
        instr = imem[m_pc[11:2]];
        f3    = instr[14:12];
        rs1v  = m_regs[instr[19:15]];
        rs2v  = m_regs[instr[24:20]];
        i_imm = {{20{instr[31]}}, instr[31:20]};
        b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        next  = m_pc + 4;
        r.pc    = m_pc;
        r.rd    = instr[11:7];
        r.we    = 1'b1;
        r.wdata = '0;
        r.instr = instr;
        case (instr[6:0])
            7'b0010011: r.wdata = alu_ref(f3, f3 == 3'b101 && instr[30], rs1v, i_imm);
            7'b0110011: r.wdata = alu_ref(f3, instr[30], rs1v, rs2v);
            7'b0110111: r.wdata = {instr[31:12], 12'b0};          // lui
            7'b0010111: r.wdata = m_pc + {instr[31:12], 12'b0};   // auipc
            7'b1101111: begin
                r.wdata = m_pc + 4;
                next    = m_pc + j_imm;
            end
            7'b1100111: begin
                r.wdata = m_pc + 4;
                next    = (rs1v + i_imm) & ~32'd1;
            end
            7'b1100011: begin
                r.we = 1'b0;
                if (branch_ref(f3, rs1v, rs2v))
                    next = m_pc + b_imm;
            end
            default: r.we = 1'b0;
        endcase
        if (r.rd == '0)
            r.we = 1'b0;
        if (r.we)
            m_regs[r.rd] = r.wdata;
        m_pc = next;
        return r;
    endfunction

    // ------------------------------
    // checking
    // ------------------------------
    task automatic report_mismatch(input string field, input rv_pkg::word_t got,
                                   input rv_pkg::word_t exp);
        $display("[FAIL] retire_o.%s got %h expected %h", field, got, exp);
        errors++;
    endtask

    task automatic check_retire();
        rv_pkg::retire_t exp;
        int              err_in;
        err_in = errors;
        exp    = ref_step();
        n_retired++;
        if (retire_o.pc !== exp.pc)
            report_mismatch("pc", retire_o.pc, exp.pc);
        if (retire_o.instr !== exp.instr)
            report_mismatch("instr", retire_o.instr, exp.instr);
        if (retire_o.we !== exp.we)
            report_mismatch("we", {31'b0, retire_o.we}, {31'b0, exp.we});
        if (exp.we && retire_o.rd !== exp.rd)
            report_mismatch("rd", {27'b0, retire_o.rd}, {27'b0, exp.rd});
        if (exp.we && retire_o.wdata !== exp.wdata)
            report_mismatch("wdata", retire_o.wdata, exp.wdata);
        if (errors != err_in || exp.pc == end_pc)
            done = 1'b1; // stream is off track or the program is over
    endtask

    always @(negedge clk) begin
        if (!active) begin
            done          = 1'b0;
            n_retired     = 0;
            since_release = 0;
            m_pc          = rv_pkg::RESET_PC;
            for (int i = 0; i < 32; i++)
                m_regs[i] = '0;
            if (!rst_n && fetch_addr_o !== rv_pkg::RESET_PC) begin
                $display("[FAIL] fetch_addr_o got %h expected %h", fetch_addr_o,
                         rv_pkg::RESET_PC);
                errors++;
            end
        end else if (!done) begin
            if (since_release < 3 && retire_valid_o !== 1'b0) begin
                $display("retire strobe seen %0d cycles after reset, too early", since_release);
                errors++;
            end
            if (since_release == 3 && retire_valid_o !== 1'b1) begin
                $display("first instruction did not retire 3 cycles after reset");
                errors++;
            end
            since_release++;
            if (retire_valid_o === 1'b1)
                check_retire();
        end
    end

    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------
    // programs
    // ------------------------------
    task automatic emit(input rv_pkg::word_t w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 1024; i++)
            imem[i] = op_imm(3'b000, 0, 0, i); // addi x0, x0, word index
    endtask

    task automatic begin_test();
        @(posedge clk);
        #1;
        rst_n         = 1'b0;
        active        = 1'b0;
        test_err_base = errors;
        wp            = 0;
        fill_memory();
    endtask

    task automatic run_test(input string name);
        end_pc   = 32'(wp * 4);
        imem[wp] = j_type(0, 0);    // jal x0, 0 closes the program
        total_len   += wp + 1;
        cycle_limit = 4 * total_len + 200;
        repeat (16) @(posedge clk);
        #1;
        active = 1'b1;
        rst_n  = 1'b1;
        wait (done);
        active = 1'b0;
        tests_run++;
        if (errors != test_err_base)
            tests_failed++;
        $display("test %0d %s: %0d retired, %0d errors, %s", tests_run, name, n_retired,
                 errors - test_err_base, (errors == test_err_base) ? "pass" : "fail");
    endtask

    task automatic build_alu_test();
        emit(op_imm(3'b000, 1, 0, 2047));
        emit(op_imm(3'b000, 2, 0, -2048));
        emit(op_reg(7'h00, 3'b000, 3, 1, 2));       // x2 back to back, x1 two apart
        emit(op_reg(7'h20, 3'b000, 4, 3, 1));
        emit(op_reg(7'h00, 3'b001, 5, 4, 1));       // shift by 31
        emit(op_reg(7'h00, 3'b010, 6, 2, 1));
        emit(op_reg(7'h00, 3'b011, 7, 2, 1));
        emit(op_reg(7'h00, 3'b100, 8, 5, 6));
        emit(op_reg(7'h00, 3'b101, 9, 2, 6));
        emit(op_reg(7'h20, 3'b101, 10, 2, 6));
        emit(op_reg(7'h00, 3'b110, 11, 9, 10));
        emit(op_reg(7'h00, 3'b111, 12, 11, 2));
        emit(op_imm(3'b001, 13, 12, 3));
        emit(op_imm(3'b101, 14, 13, 7));
        emit(op_imm(3'b101, 15, 2, 'h404));         // srai by 4
        emit(op_imm(3'b010, 16, 15, -1));
        emit(op_imm(3'b011, 17, 15, -1));
        emit(op_imm(3'b100, 18, 17, 'h555));
        emit(op_imm(3'b110, 19, 18, 'h0f0));
        emit(op_imm(3'b111, 20, 19, 'h03c));
        emit(op_reg(7'h00, 3'b000, 0, 19, 20));     // x0 write dropped
        emit(op_reg(7'h00, 3'b000, 21, 0, 20));
    endtask

    task automatic build_link_test();
        emit(u_type(7'b0110111, 1, 'h80001));
        emit(u_type(7'b0010111, 2, 'h00010));
        emit(op_imm(3'b000, 3, 2, 4));
        emit(j_type(4, 8));                         // skips one word
        emit(op_imm(3'b000, 5, 0, 1));
        emit(i_type(7'b1100111, 3'b000, 6, 0, (wp + 2) * 4));
        emit(op_imm(3'b000, 5, 0, 2));
        emit(op_reg(7'h00, 3'b000, 7, 4, 6));       // both link values
        emit(u_type(7'b0010111, 8, 'hfffff));
        emit(j_type(10, 4));
        emit(op_reg(7'h00, 3'b000, 11, 10, 1));
    endtask

    task automatic build_branch_test();
        logic [2:0] conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        int         pa [5] = '{1, 2, 3, 4, 2};
        int         pb [5] = '{2, 1, 4, 3, 5};
        emit(op_imm(3'b000, 1, 0, -1));
        emit(op_imm(3'b000, 2, 0, 1));
        emit(u_type(7'b0110111, 3, 'h80000));       // most negative
        emit(u_type(7'b0110111, 4, 'h80000));
        emit(op_imm(3'b000, 4, 4, -1));             // wraps to most positive
        emit(op_imm(3'b000, 5, 0, 1));
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                emit(b_type(conds[c], pa[p], pb[p], 12));
                emit(op_imm(3'b000, 10, 10, 1));    // only on the fall through path
                emit(op_imm(3'b000, 11, 10, 0));
            end
        end
    endtask

    task automatic build_random_test(input int n);
        int         kind;
        int         off;
        int         imm;
        logic [2:0] f3;
        logic       alt;
        for (int k = 0; k < n; k++) begin
            kind = rand_bits(4);
            off  = 1 + rand_bits(3);
            if (k + off > n)
                off = n - k;
            f3   = 3'(rand_bits(3));
            if (kind < 7) begin
                alt = (f3 == 3'b000 || f3 == 3'b101) && rand_bits(1) == 1;
                emit(op_reg(alt ? 7'h20 : 7'h00, f3, rand_bits(5), rand_bits(5), rand_bits(5)));
            end else if (kind < 11) begin
                imm = rand_bits(12);
                if (f3 == 3'b001)
                    imm = rand_bits(5);
                else if (f3 == 3'b101)
                    imm = rand_bits(5) | (rand_bits(1) << 10);
                emit(op_imm(f3, rand_bits(5), rand_bits(5), imm));
            end else if (kind == 11) begin
                emit(u_type(7'b0110111, rand_bits(5), rand_bits(20)));
            end else if (kind == 12) begin
                emit(u_type(7'b0010111, rand_bits(5), rand_bits(20)));
            end else if (kind == 13) begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;                   // no reserved conditions
                emit(b_type(f3, rand_bits(5), rand_bits(5), off * 4));
            end else if (kind == 14) begin
                emit(j_type(rand_bits(5), off * 4));
            end else begin
                emit(i_type(7'b1100111, 3'b000, rand_bits(5), 0, (k + off) * 4));
            end
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        rst_n = 1'b0;
        fill_memory();
        begin_test();
        emit(op_imm(3'b000, 1, 0, 5));
        emit(op_imm(3'b000, 2, 1, 3));
        run_test("reset");
        begin_test();
        build_alu_test();
        run_test("alu");
        begin_test();
        build_link_test();
        run_test("upper and link");
        begin_test();
        build_branch_test();
        run_test("branch");
        begin_test();
        build_random_test(300);
        run_test("random");
        $display("%0d tests, %0d passed, %0d failed, %0d check errors", tests_run,
                 tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verilog.f
source/rv_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv_core.sv
verif/tb_rv_core.sv
